/* tb.f */
+incdir+verilog
+incdir+test
verilog/slave_frame_pkg.sv
verilog/slave_link_pkg.sv
verilog/slave_frame_decode.sv
verilog/slave_write_path.sv
verilog/slave_read_path.sv
verilog/uart_slave.sv
test/tb_uart_slave.sv

/* test/tb_uart_slave_tasks.svh */
`ifndef TB_UART_SLAVE_TASKS_SVH
`define TB_UART_SLAVE_TASKS_SVH

// start code, id msb first, then rw
task automatic send_frame(input frame_code_t code, input slave_id_t id, input logic rw);
    logic [3+`UART_SLAVE_ID_WIDTH:0] bits;
    bits = {code, id, rw};
    for (int i = $bits(bits) - 1; i >= 0; i--) begin
        @(posedge clk);
        #2;
        control = bits[i];
    end
    @(posedge clk);
    #2;
    control = 1'b0;
endtask

// one bit offered per cycle while ready, with random holes in valid
task automatic write_word(input link_word_t word, input logic gaps);
    int   idx;
    int   cycles;
    logic gap;
    idx    = DW - 1;
    cycles = 0;
    while (idx >= 0 && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        #2;
        cycles++;
        gap = 1'b0;
        if (gaps) begin
            take_bit(gap);
        end
        if (ready && !gap) begin
            valid = 1'b1;
            wd    = word[idx];
            idx--;
        end else begin
            valid = 1'b0;
        end
    end
    @(posedge clk);
    #2;
    valid = 1'b0;
    wd    = 1'b0;
    if (idx >= 0) begin
        timeouts++;
        $display("timeout at %0t: ready dropped before the whole word was taken", $time);
    end
endtask

task automatic wait_s_starts(input int target);
    int cycles;
    cycles = 0;
    while (s_starts < target && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        cycles++;
    end
    if (s_starts < target) begin
        timeouts++;
        $display("timeout at %0t: send link saw %0d starts, waiting for %0d",
                 $time, s_starts, target);
    end
endtask

task automatic wait_replies(input int target);
    int cycles;
    cycles = 0;
    while (replies < target && cycles < WAIT_LIMIT) begin
        @(posedge clk);
        cycles++;
    end
    if (replies < target) begin
        timeouts++;
        $display("timeout at %0t: acknowledge was never sent back", $time);
    end
endtask

task automatic present_get_word(input link_word_t w);
    repeat (3) @(posedge clk);
    #2;
    g_rx.done = 1'b1;
    g_rx.word = w;
    @(posedge clk);
    #2;
    g_rx.done = 1'b0;
endtask

// rd taken on every ready-high cycle with the status nibble first
task automatic read_word(output ack_status_t st, output link_word_t w);
    logic [4+DW-1:0] bits;
    int              waited;
    int              high;
    bits   = '0;
    waited = 0;
    high   = 0;
    @(negedge clk);
    while (!ready && waited < WAIT_LIMIT) begin
        @(negedge clk);
        waited++;
    end
    if (!ready) begin
        timeouts++;
        $display("timeout at %0t: ready never rose for the read", $time);
    end
    while (ready && high < 2 * (4 + DW)) begin
        bits = {bits[4+DW-2:0], rd};
        high++;
        @(negedge clk);
    end
    compare_count("ready cycles", high, 4 + DW);
    st = bits[4+DW-1:DW];
    w  = bits[DW-1:0];
endtask

task automatic check_read(input ack_status_t exp_status, input link_word_t gword,
                          input int gbase);
    ack_status_t st;
    link_word_t  w;
    read_word(st, w);
    compare_status("rd status", st, exp_status);
    compare_word("rd word", w, gword);
    compare_count("g_tx starts", g_starts - gbase, 1);
    compare_word("g_tx.word", last_g_word, ACK_WORD);
    // let the decoder leave BUSY
    repeat (2) @(posedge clk);
endtask

task automatic do_read(input ack_status_t exp_status);
    link_word_t gword;
    int         gbase;
    random_word(gword);
    gbase = g_starts;
    send_frame(GOOD_CODE, SELF_ID, 1'b0);
    present_get_word(gword);
    check_read(exp_status, gword, gbase);
endtask

task automatic do_write(input link_word_t word, input logic reply_on, input logic [7:0] rbyte);
    int base;
    int rbase;
    base         = s_starts;
    rbase        = replies;
    reply_enable = reply_on;
    reply_byte   = rbyte;
    send_frame(GOOD_CODE, SELF_ID, 1'b1);
    write_word(word, 1'b1);
    if (reply_on) begin
        wait_s_starts(base + 1);
        wait_replies(rbase + 1);
    end else begin
        wait_s_starts(base + 1 + RETX);
    end
    // a late resend would land inside one more acknowledge window
    repeat (ACK_TIMEOUT + 6) @(posedge clk);
    compare_count("s_tx starts", s_starts - base, reply_on ? 1 : 1 + RETX);
    for (int i = base; i < s_starts; i++) begin
        compare_word("s_tx.word", s_words[i], word);
    end
    reply_enable = 1'b0;
endtask

// nothing may answer a frame that was not for this slave
task automatic watch_quiet(input int cycles);
    for (int i = 0; i < cycles; i++) begin
        @(negedge clk);
        compare_bit("ready", ready, 1'b0);
        compare_bit("s_tx.start", s_tx.start, 1'b0);
        compare_bit("g_tx.start", g_tx.start, 1'b0);
    end
endtask

task automatic test_write_ack();
    link_word_t w;
    random_word(w);
    do_write(w, 1'b1, ACK_BYTE);
    do_read(ACK_STATUS);
endtask

task automatic test_write_nak();
    link_word_t w;
    random_word(w);
    do_write(w, 1'b1, NAK_BYTE);
    do_read(NAK_STATUS);
endtask

task automatic test_bad_frames();
    link_word_t w;
    send_frame(3'b101, SELF_ID, 1'b1);
    watch_quiet(DW + 8);
    send_frame(GOOD_CODE, SELF_ID ^ 2'b11, 1'b1);
    watch_quiet(DW + 8);
    random_word(w);
    do_write(w, 1'b1, ACK_BYTE);
    do_read(ACK_STATUS);
endtask

task automatic test_write_no_reply();
    link_word_t w;
    random_word(w);
    do_write(w, 1'b0, 8'h00);
    do_read(NAK_STATUS);
endtask

task automatic test_slow_read();
    link_word_t gword;
    int         gbase;
    random_word(gword);
    gbase = g_starts;
    @(posedge clk);
    #2;
    g_tx_ready = 1'b0;
    send_frame(GOOD_CODE, SELF_ID, 1'b0);
    present_get_word(gword);
    for (int i = 0; i < 12; i++) begin
        @(negedge clk);
        compare_bit("g_tx.start", g_tx.start, 1'b0);
        compare_bit("ready", ready, 1'b0);
    end
    @(posedge clk);
    #2;
    g_tx_ready = 1'b1;
    check_read(NAK_STATUS, gword, gbase);
endtask

`endif

/* test/tb_uart_slave.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_defines.svh"

module tb_uart_slave;
    import slave_frame_pkg::*;
    import slave_link_pkg::*;

    localparam int DW          = `UART_SLAVE_DATA_WIDTH;
    localparam int RETX        = `UART_SLAVE_RETRANSMITS;
    localparam int ACK_TIMEOUT = `UART_SLAVE_ACK_TIMEOUT;
    localparam int WAIT_LIMIT  = 400;

    localparam frame_code_t GOOD_CODE  = 3'b111;
    localparam slave_id_t   SELF_ID    = slave_id_t'(`UART_SLAVE_SLAVE_ID);
    localparam ack_status_t ACK_STATUS = 4'hC;
    localparam ack_status_t NAK_STATUS = 4'hA;
    localparam logic [7:0]  ACK_BYTE   = 8'hCC;
    localparam logic [7:0]  NAK_BYTE   = 8'hAA;
    localparam link_word_t  ACK_WORD   = link_word_t'(ACK_BYTE);

    logic    clk = 1'b0;
    logic    rstN;
    logic    control;
    logic    wd;
    logic    valid;
    logic    rd;
    logic    ready;
    tx_req_t s_tx;
    logic    s_tx_ready;
    rx_ind_t s_rx;
    tx_req_t g_tx;
    logic    g_tx_ready;
    rx_ind_t g_rx;

    // send-link model state
    logic       reply_enable = 1'b0;
    logic [7:0] reply_byte   = 8'h00;
    int         reply_delay  = 5;
    int         reply_cnt    = 0;
    int         replies      = 0;
    int         s_starts     = 0;
    link_word_t s_words[$];

    // get-link model state
    int         g_starts     = 0;
    link_word_t last_g_word  = '0;

    logic [31:0] lfsr_q   = 32'h1f9c_f10f;
    int          checks   = 0;
    int          errors   = 0;
    int          timeouts = 0;

    always #10 clk = ~clk;

    uart_slave uart_slave_inst (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .wd         (wd),
        .valid      (valid),
        .rd         (rd),
        .ready      (ready),
        .s_tx       (s_tx),
        .s_tx_ready (s_tx_ready),
        .s_rx       (s_rx),
        .g_tx       (g_tx),
        .g_tx_ready (g_tx_ready),
        .g_rx       (g_rx)
    );

    // next board, counts starts and answers after reply_delay cycles
    always @(negedge clk) begin
        if (s_tx.start) begin
            s_starts++;
            s_words.push_back(s_tx.word);
            if (reply_enable) begin
                reply_cnt = reply_delay;
            end
        end
    end

    always @(posedge clk) begin
        #2;
        if (reply_cnt == 1) begin
            s_rx.done = 1'b1;
            s_rx.word = link_word_t'(reply_byte);
            replies++;
        end else begin
            s_rx.done = 1'b0;
        end
        if (reply_cnt > 0) begin
            reply_cnt--;
        end
    end

    // previous board, only records what comes back
    always @(negedge clk) begin
        if (g_tx.start) begin
            g_starts++;
            last_g_word = g_tx.word;
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bit(output logic b);
        lfsr_q = lfsr_next(lfsr_q);
        b = lfsr_q[0];
    endtask

    task automatic random_word(output link_word_t w);
        logic b;
        for (int i = 0; i < DW; i++) begin
            take_bit(b);
            w = {w[DW-2:0], b};
        end
    endtask

    task automatic compare_word(input string name, input link_word_t got, input link_word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_status(input string name, input ack_status_t got,
                                  input ack_status_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    `include "tb_uart_slave_tasks.svh"

    initial begin
        rstN       = 1'b0;
        control    = 1'b0;
        wd         = 1'b0;
        valid      = 1'b0;
        s_tx_ready = 1'b1;
        s_rx       = '0;
        g_tx_ready = 1'b1;
        g_rx       = '0;
        repeat (5) @(posedge clk);
        #2;
        rstN = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_bit("ready", ready, 1'b0);
        compare_bit("rd", rd, 1'b0);
        compare_bit("s_tx.start", s_tx.start, 1'b0);
        compare_bit("g_tx.start", g_tx.start, 1'b0);

        test_write_ack();
        test_write_nak();
        test_bad_frames();
        test_write_no_reply();
        test_slow_read();

        $display("checks: %0d, mismatches: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // last resort if a model or the DUT stalls the whole run
    initial begin
        #500_000;
        $display("simulation ran past its time limit");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/slave_frame_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_defines.svh"

module slave_frame_decode (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire                         control,
    input  wire                         write_done,
    input  wire                         read_done,
    output slave_frame_pkg::frame_cmd_t cmd
);
    import slave_frame_pkg::*;

    // start code, slave id, rw bit
    localparam int CON   = 3 + `UART_SLAVE_ID_WIDTH + 1;
    localparam int CNT_W = $clog2(CON);

    decode_state_t    state;
    logic [CON-2:0]   shift_q;
    logic [CNT_W-1:0] bit_cnt;
    logic [CON-1:0]   frame;
    frame_code_t      code;
    slave_id_t        id;
    logic             match;

    // frame as it stands with the current control bit appended
    assign frame = {shift_q, control};
    assign code  = frame[CON-1 -: 3];
    assign id    = frame[`UART_SLAVE_ID_WIDTH:1];
    assign match = (code == START_CODE) && (id == slave_id_t'(`UART_SLAVE_SLAVE_ID));

    always_ff @(posedge clk) begin
        shift_q <= frame[CON-2:0];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            bit_cnt <= '0;
            cmd     <= '0;
        end else begin
            cmd.valid <= 1'b0;
            case (state)
                IDLE: begin
                    // first high control bit opens a frame
                    if (control) begin
                        bit_cnt <= CNT_W'(1);
                        state   <= SHIFT;
                    end
                end
                SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(CON - 1)) begin
                        cmd.valid <= match;
                        cmd.write <= control;
                        state     <= match ? BUSY : IDLE;
                    end
                end
                BUSY: begin
                    // control ignored until the transfer ends
                    if (write_done || read_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/slave_frame_pkg.sv */
`default_nettype none

`include "uart_slave_defines.svh"

package slave_frame_pkg;

    // id field of a control frame
    typedef logic [`UART_SLAVE_ID_WIDTH-1:0] slave_id_t;

    // leading code of a control frame
    typedef logic [2:0] frame_code_t;

    localparam frame_code_t START_CODE = 3'b111;

    // decoded command, valid for one cycle
    typedef struct packed {
        logic valid;
        logic write;
    } frame_cmd_t;

    // decoder FSM
    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        BUSY
    } decode_state_t;

endpackage

`default_nettype wire

/* verilog/slave_link_pkg.sv */
`default_nettype none

`include "uart_slave_defines.svh"

package slave_link_pkg;

    typedef logic [`UART_SLAVE_DATA_WIDTH-1:0] link_word_t;

    // acknowledge bytes exchanged between boards
    typedef enum logic [7:0] {
        ACK = 8'hCC,
        NAK = 8'hAA
    } ack_code_t;

    // upper nibble of an ack code, as reported to the master
    typedef logic [3:0] ack_status_t;

    // request toward a link transmitter
    typedef struct packed {
        logic       start;
        link_word_t word;
    } tx_req_t;

    // indication from a link receiver
    typedef struct packed {
        logic       done;
        link_word_t word;
    } rx_ind_t;

    typedef enum logic [2:0] {
        IDLE,
        SHIFT,
        SEND,
        WAIT_ACK,
        CHECK
    } write_state_t;

    typedef enum logic [1:0] {
        WAIT_RX,
        SEND_ACK,
        SHIFT_OUT
    } read_state_t;

endpackage

`default_nettype wire

/* verilog/slave_read_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_defines.svh"

module slave_read_path (
    input  wire                              clk,
    input  wire                              rstN,
    input  wire slave_frame_pkg::frame_cmd_t  cmd,
    input  wire slave_link_pkg::ack_status_t status,
    input  wire slave_link_pkg::rx_ind_t     g_rx,
    output slave_link_pkg::tx_req_t          g_tx,
    input  wire                              g_tx_ready,
    output logic                             rd,
    output logic                             ready,
    output logic                             done
);
    import slave_link_pkg::*;

    localparam int DW    = `UART_SLAVE_DATA_WIDTH;
    localparam int OUT_W = 4 + DW;
    localparam int CNT_W = $clog2(OUT_W + 1);

    localparam logic [CNT_W-1:0] OUT_LAST = CNT_W'(OUT_W);
    localparam logic [7:0]       ACK_BYTE = ACK;

    read_state_t      state;
    logic             active;
    logic             start_q;
    logic [OUT_W-1:0] out_q;
    logic [CNT_W-1:0] bit_cnt;

    // previous board only ever gets ACK back
    assign g_tx = '{start: start_q, word: link_word_t'(ACK_BYTE)};

    // status nibble leads, then the word, both msb first
    always_ff @(posedge clk) begin
        if (state == WAIT_RX && active && g_rx.done) begin
            out_q <= {status, g_rx.word};
        end else if (state == SHIFT_OUT && bit_cnt != OUT_LAST) begin
            out_q <= {out_q[OUT_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= WAIT_RX;
            active  <= 1'b0;
            start_q <= 1'b0;
            rd      <= 1'b0;
            ready   <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end else begin
            start_q <= 1'b0;
            done    <= 1'b0;
            case (state)
                WAIT_RX: begin
                    if (cmd.valid && !cmd.write) begin
                        active <= 1'b1;
                    end
                    if (active && g_rx.done) begin
                        state <= SEND_ACK;
                    end
                end
                SEND_ACK: begin
                    if (g_tx_ready) begin
                        start_q <= 1'b1;
                        bit_cnt <= '0;
                        state   <= SHIFT_OUT;
                    end
                end
                SHIFT_OUT: begin
                    // no back-pressure, one bit per cycle
                    if (bit_cnt == OUT_LAST) begin
                        ready  <= 1'b0;
                        rd     <= 1'b0;
                        done   <= 1'b1;
                        active <= 1'b0;
                        state  <= WAIT_RX;
                    end else begin
                        ready   <= 1'b1;
                        rd      <= out_q[OUT_W-1];
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= WAIT_RX;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/slave_write_path.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_slave_defines.svh"

module slave_write_path (
    input  wire                             clk,
    input  wire                             rstN,
    input  wire slave_frame_pkg::frame_cmd_t cmd,
    input  wire                             wd,
    input  wire                             valid,
    output logic                            ready,
    output slave_link_pkg::tx_req_t         s_tx,
    input  wire                             s_tx_ready,
    input  wire slave_link_pkg::rx_ind_t    s_rx,
    output slave_link_pkg::ack_status_t     status,
    output logic                            done
);
    import slave_link_pkg::*;

    localparam int DW    = `UART_SLAVE_DATA_WIDTH;
    localparam int BIT_W = $clog2(DW + 1);
    localparam int TO_W  = $clog2(`UART_SLAVE_ACK_TIMEOUT + 1);
    localparam int RT_W  = $clog2(`UART_SLAVE_RETRANSMITS + 1);

    localparam logic [BIT_W-1:0] LAST_BIT  = BIT_W'(DW - 1);
    localparam logic [TO_W-1:0]  LAST_TICK = TO_W'(`UART_SLAVE_ACK_TIMEOUT - 1);
    localparam logic [RT_W-1:0]  MAX_RETX  = RT_W'(`UART_SLAVE_RETRANSMITS);
    localparam logic [7:0]       ACK_BYTE  = ACK;
    localparam logic [7:0]       NAK_BYTE  = NAK;

    write_state_t     state;
    link_word_t       word_q;
    logic [7:0]       ack_byte;
    logic [BIT_W-1:0] bit_cnt;
    logic [TO_W-1:0]  tick_cnt;
    logic [RT_W-1:0]  retx_cnt;
    logic             start_q;

    // same word goes out on every retransmit
    assign s_tx = '{start: start_q, word: word_q};

    // msb first, one bit per valid beat
    always_ff @(posedge clk) begin
        if (state == SHIFT && valid && ready) begin
            word_q <= {word_q[DW-2:0], wd};
        end
    end

    // a missing reply reads as NAK
    always_ff @(posedge clk) begin
        if (state == WAIT_ACK) begin
            ack_byte <= s_rx.done ? s_rx.word[7:0] : NAK_BYTE;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= IDLE;
            ready    <= 1'b0;
            start_q  <= 1'b0;
            done     <= 1'b0;
            status   <= '0;
            bit_cnt  <= '0;
            tick_cnt <= '0;
            retx_cnt <= '0;
        end else begin
            start_q <= 1'b0;
            done    <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd.valid && cmd.write) begin
                        ready    <= 1'b1;
                        bit_cnt  <= '0;
                        retx_cnt <= '0;
                        state    <= SHIFT;
                    end
                end
                SHIFT: begin
                    // gaps in valid stall the count
                    if (valid && ready) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            ready <= 1'b0;
                            state <= SEND;
                        end
                    end
                end
                SEND: begin
                    if (s_tx_ready) begin
                        start_q  <= 1'b1;
                        tick_cnt <= '0;
                        state    <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (s_rx.done) begin
                        state <= CHECK;
                    end else if (tick_cnt == LAST_TICK) begin
                        if (retx_cnt == MAX_RETX) begin
                            state <= CHECK;
                        end else begin
                            retx_cnt <= retx_cnt + 1'b1;
                            state    <= SEND;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                CHECK: begin
                    status <= (ack_byte == ACK_BYTE) ? ACK_BYTE[7:4] : NAK_BYTE[7:4];
                    done   <= 1'b1;
                    state  <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_slave (
    input  wire                          clk,
    input  wire                          rstN,
    input  wire                          control,
    input  wire                          wd,
    input  wire                          valid,
    output logic                         rd,
    output logic                         ready,
    output slave_link_pkg::tx_req_t      s_tx,
    input  wire                          s_tx_ready,
    input  wire slave_link_pkg::rx_ind_t s_rx,
    output slave_link_pkg::tx_req_t      g_tx,
    input  wire                          g_tx_ready,
    input  wire slave_link_pkg::rx_ind_t g_rx
);
    import slave_frame_pkg::*;
    import slave_link_pkg::*;

    frame_cmd_t  cmd;
    ack_status_t status;
    logic        write_done;
    logic        read_done;
    logic        write_ready;
    logic        read_ready;

    slave_frame_decode frame_decode_inst (
        .clk        (clk),
        .rstN       (rstN),
        .control    (control),
        .write_done (write_done),
        .read_done  (read_done),
        .cmd        (cmd)
    );

    slave_write_path write_path_inst (
        .clk        (clk),
        .rstN       (rstN),
        .cmd        (cmd),
        .wd         (wd),
        .valid      (valid),
        .ready      (write_ready),
        .s_tx       (s_tx),
        .s_tx_ready (s_tx_ready),
        .s_rx       (s_rx),
        .status     (status),
        .done       (write_done)
    );

    slave_read_path read_path_inst (
        .clk        (clk),
        .rstN       (rstN),
        .cmd        (cmd),
        .status     (status),
        .g_rx       (g_rx),
        .g_tx       (g_tx),
        .g_tx_ready (g_tx_ready),
        .rd         (rd),
        .ready      (read_ready),
        .done       (read_done)
    );

    // only one path is active at a time
    assign ready = write_ready | read_ready;

endmodule

`default_nettype wire

/* verilog/uart_slave_defines.svh */
`ifndef UART_SLAVE_DEFINES_SVH
`define UART_SLAVE_DEFINES_SVH

// word carried in both directions
`define UART_SLAVE_DATA_WIDTH 32

// slaves on the bus and the id of this one
`define UART_SLAVE_SLAVES 3
`define UART_SLAVE_SLAVE_ID 1

// bit count of SLAVES+1
`define UART_SLAVE_ID_WIDTH 2

// cycles to wait for an acknowledge after each start
`define UART_SLAVE_ACK_TIMEOUT 16

// resends after the first start
`define UART_SLAVE_RETRANSMITS 3

`endif
